// ==== include/frontend_config.svh ====
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// first instruction address after reset
`define FE_RESET_PC    32'h1C00_0000

// instruction word and address width
`define FE_INST_W      32

// major opcodes, left-aligned at bit 31 of the word
// add.w: 3R format, bits [31:15]
`define FE_OP_ADD_W    17'h0_0020
// addi.w: 2RI12 format, bits [31:22]
`define FE_OP_ADDI_W   10'h00A
// lu12i.w: 1RI20 format, bits [31:25]
`define FE_OP_LU12I_W  7'h0A
// b and bl: I26 format, bits [31:26]
`define FE_OP_B        6'h14
`define FE_OP_BL       6'h15

`endif

// ==== run.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 -f src.f --top-module tb_frontend \
    && ./obj_dir/Vtb_frontend | tee sim.log \
    && grep -q "^Finished with no errors$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== source/branch_resolver.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frontend_config.svh"

module branch_resolver (
    input  frontend_pkg::inst_word_t    inst,
    input  logic [`FE_INST_W-1:0]       pc,
    // instruction leaves decode this cycle
    input  logic                        fire,
    output logic                        br_taken,
    output logic [`FE_INST_W-1:0]       br_target,
    output logic [`FE_INST_W-1:0]       link
);

    logic                   is_branch;
    logic [25:0]            offs26;
    logic [`FE_INST_W-1:0]  offs_ext;

    // b and bl are both unconditional
    assign is_branch = (inst.offs26.opcode == `FE_OP_B) ||
                       (inst.offs26.opcode == `FE_OP_BL);

    assign offs26   = {inst.offs26.offs_hi, inst.offs26.offs_lo};
    assign offs_ext = {{4{offs26[25]}}, offs26, 2'b00};

    // pc relative target
    assign br_target = pc + offs_ext;

    // return address, only meaningful for bl
    assign link = pc + 32'd4;

    // one pulse per branch, as it hands off to execute
    assign br_taken = fire & is_branch;

endmodule

`default_nettype wire

// ==== source/fetch_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frontend_config.svh"

module fetch_frontend (
    input  logic                        clk,
    input  logic                        resetn,

    // instruction sram
    output logic                        inst_sram_en,
    output logic [`FE_INST_W-1:0]       inst_sram_addr,
    input  logic [`FE_INST_W-1:0]       inst_sram_rdata,

    // execute side
    input  logic                        ex_allowin,
    output logic                        id_to_ex_valid,
    output logic [`FE_INST_W-1:0]       id_to_ex_pc,
    output frontend_pkg::dec_fields_t   id_to_ex_fields,
    output logic [`FE_INST_W-1:0]       id_to_ex_link
);

    logic                   br_taken;
    logic [`FE_INST_W-1:0]  br_target;

    if_id_bus_if if_id_bus ();

    if_stage u_if_stage (
        .clk             (clk),
        .resetn          (resetn),
        .br_taken        (br_taken),
        .br_target       (br_target),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .bus             (if_id_bus.fetch_side)
    );

    // branch resolved in decode, redirect goes back the same cycle
    id_stage u_id_stage (
        .clk             (clk),
        .resetn          (resetn),
        .ex_allowin      (ex_allowin),
        .bus             (if_id_bus.decode_side),
        .br_taken        (br_taken),
        .br_target       (br_target),
        .id_to_ex_valid  (id_to_ex_valid),
        .id_to_ex_pc     (id_to_ex_pc),
        .id_to_ex_fields (id_to_ex_fields),
        .id_to_ex_link   (id_to_ex_link)
    );

endmodule

`default_nettype wire

// ==== source/frontend_pkg.sv ====
`default_nettype none

`include "frontend_config.svh"

package frontend_pkg;

    // 3R view, e.g. add.w
    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_reg3_t;

    // 2RI12 view, e.g. addi.w
    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] si12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_imm12_t;

    // I26 view for b and bl
    // offset is split, low half sits above the high half
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } inst_offs26_t;

    // one fetched word, read through whichever format applies
    typedef union packed {
        inst_reg3_t   reg3;
        inst_imm12_t  imm12;
        inst_offs26_t offs26;
    } inst_word_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_ADDI,
        OP_LU12I,
        OP_B,
        OP_BL,
        OP_INVALID
    } op_class_e;

    // decoded result handed toward execute
    // unused register fields are zero for the class
    typedef struct packed {
        op_class_e              op_class;
        logic [4:0]             rd;
        logic [4:0]             rj;
        logic [4:0]             rk;
        logic [`FE_INST_W-1:0]  imm;
    } dec_fields_t;

endpackage

`default_nettype wire

// ==== source/id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frontend_config.svh"

module id_stage (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        ex_allowin,

    if_id_bus_if.decode_side            bus,

    // redirect toward fetch
    output logic                        br_taken,
    output logic [`FE_INST_W-1:0]       br_target,

    // toward execute
    output logic                        id_to_ex_valid,
    output logic [`FE_INST_W-1:0]       id_to_ex_pc,
    output frontend_pkg::dec_fields_t   id_to_ex_fields,
    output logic [`FE_INST_W-1:0]       id_to_ex_link
);

    logic                       id_valid;
    logic [`FE_INST_W-1:0]      id_pc;
    frontend_pkg::inst_word_t   id_inst;
    logic                       id_allowin;
    logic                       id_fire;
    logic                       take_offer;
    frontend_pkg::dec_fields_t  dec_fields;
    logic [`FE_INST_W-1:0]      br_link;

    assign id_allowin  = ~id_valid | ex_allowin;
    assign bus.allowin = id_allowin;

    // handoff to execute
    assign id_fire = id_valid & ex_allowin;

    // the word behind a taken branch is wrong path, drop it
    assign take_offer = id_allowin & bus.valid & ~br_taken;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (id_allowin) begin
            id_valid <= bus.valid & ~br_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (take_offer) begin
            id_pc   <= bus.pc;
            id_inst <= bus.inst;
        end
    end

    inst_decoder u_inst_decoder (
        .inst   (id_inst),
        .fields (dec_fields)
    );

    branch_resolver u_branch_resolver (
        .inst      (id_inst),
        .pc        (id_pc),
        .fire      (id_fire),
        .br_taken  (br_taken),
        .br_target (br_target),
        .link      (br_link)
    );

    assign id_to_ex_valid = id_valid;
    assign id_to_ex_pc    = id_pc;

    // bl writes its return address to r1
    always_comb begin
        id_to_ex_fields = dec_fields;
        id_to_ex_link   = '0;
        if (dec_fields.op_class == frontend_pkg::OP_BL) begin
            id_to_ex_fields.rd = 5'd1;
            id_to_ex_link      = br_link;
        end
    end

endmodule

`default_nettype wire

// ==== source/if_id_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frontend_config.svh"

// fetch to decode handoff
interface if_id_bus_if;

    logic                   valid;
    logic                   allowin;
    logic [`FE_INST_W-1:0]  pc;
    logic [`FE_INST_W-1:0]  inst;

    modport fetch_side (
        output valid,
        output pc,
        output inst,
        input  allowin
    );

    modport decode_side (
        input  valid,
        input  pc,
        input  inst,
        output allowin
    );

endinterface

`default_nettype wire

// ==== source/if_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frontend_config.svh"

module if_stage (
    input  logic                    clk,
    input  logic                    resetn,

    // redirect from decode
    input  logic                    br_taken,
    input  logic [`FE_INST_W-1:0]   br_target,

    // instruction sram, read only
    output logic                    inst_sram_en,
    output logic [`FE_INST_W-1:0]   inst_sram_addr,
    input  logic [`FE_INST_W-1:0]   inst_sram_rdata,

    if_id_bus_if.fetch_side         bus
);

    logic [`FE_INST_W-1:0] pc_q;
    logic                  valid_q;
    logic                  if_allowin;
    logic [`FE_INST_W-1:0] seq_pc;
    logic [`FE_INST_W-1:0] next_pc;

    // single cycle stage, ready as soon as the sram word is back
    assign if_allowin = ~valid_q | bus.allowin;

    assign seq_pc  = pc_q + 32'd4;
    assign next_pc = br_taken ? br_target : seq_pc;

    // request only when the fetched word has somewhere to go
    assign inst_sram_en   = if_allowin & resetn;
    assign inst_sram_addr = next_pc;

    // valid rises one cycle after the first request
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (if_allowin) begin
            valid_q <= 1'b1;
        end
    end

    // pc tracks the address of the word now returned by the sram
    // reset one word early so the first request hits the reset pc
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc_q <= `FE_RESET_PC - 32'd4;
        end else if (if_allowin) begin
            pc_q <= next_pc;
        end
    end

    // sram keeps its output while stalled, so inst is stable
    assign bus.valid = valid_q;
    assign bus.pc    = pc_q;
    assign bus.inst  = inst_sram_rdata;

endmodule

`default_nettype wire

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frontend_config.svh"

module inst_decoder (
    input  frontend_pkg::inst_word_t   inst,
    output frontend_pkg::dec_fields_t  fields
);

    logic                   is_add;
    logic                   is_addi;
    logic                   is_lu12i;
    logic                   is_b;
    logic                   is_bl;
    logic [19:0]            si20;
    logic [25:0]            offs26;
    logic [`FE_INST_W-1:0]  imm_si12;
    logic [`FE_INST_W-1:0]  imm_si20;
    logic [`FE_INST_W-1:0]  imm_offs;

    // opcode match, the encodings do not overlap
    assign is_add   = (inst.reg3.opcode == `FE_OP_ADD_W);
    assign is_addi  = (inst.imm12.opcode == `FE_OP_ADDI_W);
    assign is_lu12i = (inst.reg3.opcode[16:10] == `FE_OP_LU12I_W);
    assign is_b     = (inst.offs26.opcode == `FE_OP_B);
    assign is_bl    = (inst.offs26.opcode == `FE_OP_BL);

    // si20 of lu12i.w lives in bits [24:5]
    assign si20   = {inst.imm12.opcode[2:0], inst.imm12.si12, inst.imm12.rj};
    assign offs26 = {inst.offs26.offs_hi, inst.offs26.offs_lo};

    assign imm_si12 = {{20{inst.imm12.si12[11]}}, inst.imm12.si12};
    assign imm_si20 = {si20, 12'b0};
    // byte offset, word aligned
    assign imm_offs = {{4{offs26[25]}}, offs26, 2'b00};

    always_comb begin
        fields.op_class = frontend_pkg::OP_INVALID;
        fields.rd       = 5'd0;
        fields.rj       = 5'd0;
        fields.rk       = 5'd0;
        fields.imm      = '0;

        if (is_add) begin
            fields.op_class = frontend_pkg::OP_ADD;
            fields.rd       = inst.reg3.rd;
            fields.rj       = inst.reg3.rj;
            fields.rk       = inst.reg3.rk;
        end else if (is_addi) begin
            fields.op_class = frontend_pkg::OP_ADDI;
            fields.rd       = inst.imm12.rd;
            fields.rj       = inst.imm12.rj;
            fields.imm      = imm_si12;
        end else if (is_lu12i) begin
            // only rd, source registers stay zero
            fields.op_class = frontend_pkg::OP_LU12I;
            fields.rd       = inst.reg3.rd;
            fields.imm      = imm_si20;
        end else if (is_b) begin
            fields.op_class = frontend_pkg::OP_B;
            fields.imm      = imm_offs;
        end else if (is_bl) begin
            // link register is set later in decode
            fields.op_class = frontend_pkg::OP_BL;
            fields.imm      = imm_offs;
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
source/frontend_pkg.sv
source/if_id_bus_if.sv
source/if_stage.sv
source/inst_decoder.sv
source/branch_resolver.sv
source/id_stage.sv
source/fetch_frontend.sv
verif/tb_frontend.sv

// ==== verif/tb_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frontend_config.svh"

module tb_frontend;

    localparam int MODE_STRAIGHT = 0;
    localparam int MODE_FORWARD  = 1;
    localparam int MODE_LOOP     = 2;

    // one expected handoff toward execute
    typedef struct packed {
        logic [31:0]                pc;
        frontend_pkg::dec_fields_t  fields;
        logic [31:0]                link;
        logic [31:0]                next_pc;
    } exp_t;

    logic                       clk = 1'b0;
    logic                       resetn;
    logic                       inst_sram_en;
    logic [31:0]                inst_sram_addr;
    logic [31:0]                inst_sram_rdata = 32'h0;
    logic                       ex_allowin = 1'b0;
    logic                       id_to_ex_valid;
    logic [31:0]                id_to_ex_pc;
    frontend_pkg::dec_fields_t  id_to_ex_fields;
    logic [31:0]                id_to_ex_link;

    logic [31:0]                mem [logic [31:0]];
    exp_t                       exp_q [$];
    logic                       req_en;
    logic [31:0]                req_addr;
    logic                       checking;
    logic                       bp_on;
    int                         n_checked = 0;
    int                         checks = 0;
    int                         errors = 0;
    int                         flow_errors = 0;
    logic                       hold_pending;
    logic [31:0]                hold_pc;
    frontend_pkg::dec_fields_t  hold_fields;
    logic [31:0]                hold_link;

    fetch_frontend DUT (
        .clk             (clk),
        .resetn          (resetn),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .ex_allowin      (ex_allowin),
        .id_to_ex_valid  (id_to_ex_valid),
        .id_to_ex_pc     (id_to_ex_pc),
        .id_to_ex_fields (id_to_ex_fields),
        .id_to_ex_link   (id_to_ex_link)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // top opcode 6'h3f matches no recognized class
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {6'h3F, addr[25:0] ^ addr[31:6]};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return fill_word(addr);
    endfunction

    function automatic logic [31:0] plain_word(input int kind);
        logic [31:0] r;
        r = $urandom;
        case (kind)
            0:       return {`FE_OP_ADD_W, r[14:0]};
            1:       return {`FE_OP_ADDI_W, r[21:0]};
            2:       return {`FE_OP_LU12I_W, r[24:0]};
            default: return {6'h3F, r[25:0]};
        endcase
    endfunction

    // offset in words with the low 16 bits above the high 10
    function automatic logic [31:0] branch_word(input logic [5:0] op, input int off);
        logic [25:0] o;
        o = off[25:0];
        return {op, o[15:0], o[25:16]};
    endfunction

    function automatic exp_t ref_decode(input logic [31:0] word, input logic [31:0] pc);
        exp_t        e;
        logic [25:0] offs;
        e = '0;
        e.pc = pc;
        e.next_pc = pc + 32'd4;
        e.fields.op_class = frontend_pkg::OP_INVALID;
        offs = {word[9:0], word[25:10]};
        if (word[31:15] == `FE_OP_ADD_W) begin
            e.fields.op_class = frontend_pkg::OP_ADD;
            e.fields.rd = word[4:0];
            e.fields.rj = word[9:5];
            e.fields.rk = word[14:10];
        end else if (word[31:22] == `FE_OP_ADDI_W) begin
            e.fields.op_class = frontend_pkg::OP_ADDI;
            e.fields.rd = word[4:0];
            e.fields.rj = word[9:5];
            e.fields.imm = {{20{word[21]}}, word[21:10]};
        end else if (word[31:25] == `FE_OP_LU12I_W) begin
            e.fields.op_class = frontend_pkg::OP_LU12I;
            e.fields.rd = word[4:0];
            e.fields.imm = {word[24:5], 12'h000};
        end else if (word[31:26] == `FE_OP_B || word[31:26] == `FE_OP_BL) begin
            e.fields.op_class = frontend_pkg::OP_B;
            e.fields.imm = {{4{offs[25]}}, offs, 2'b00};
            e.next_pc = pc + e.fields.imm;
            if (word[31:26] == `FE_OP_BL) begin
                e.fields.op_class = frontend_pkg::OP_BL;
                e.fields.rd = 5'd1;
                e.link = pc + 32'd4;
            end
        end
        return e;
    endfunction

    // last word always jumps back to the start
    task automatic build_program(input int n, input int mode);
        int          kind;
        int          off;
        logic [31:0] addr;
        logic [5:0]  op;
        mem.delete();
        for (int i = 0; i < n; i++) begin
            addr = `FE_RESET_PC + 4 * i;
            kind = $urandom % 8;
            op = ($urandom % 2 == 0) ? `FE_OP_B : `FE_OP_BL;
            if (i == n - 1) begin
                mem[addr] = branch_word(`FE_OP_B, -(n - 1));
            end else if (mode != MODE_STRAIGHT && kind >= 6 && i >= 2) begin
                if (mode == MODE_LOOP && kind == 7) begin
                    off = -(1 + ($urandom % 4));
                    if (i + off < 0) begin
                        off = -i;
                    end
                end else begin
                    off = 1 + ($urandom % 3);
                    if (i + off > n - 1) begin
                        off = n - 1 - i;
                    end
                end
                mem[addr] = branch_word(op, off);
            end else begin
                mem[addr] = plain_word(kind % 4);
            end
        end
    endtask

    // request sampled on the rising edge and the word driven on the falling edge
    always @(posedge clk) begin
        req_en   <= inst_sram_en;
        req_addr <= inst_sram_addr;
    end

    always @(negedge clk) begin
        if (req_en) begin
            inst_sram_rdata = fetch_word(req_addr);
        end
        ex_allowin = bp_on ? (($urandom % 4) != 0) : 1'b1;
    end

    // compares every handoff with the head of the reference queue
    always @(posedge clk) begin
        exp_t e;
        if (!checking) begin
            hold_pending = 1'b0;
        end else begin
            if (hold_pending) begin
                checks++;
                assert (id_to_ex_valid && id_to_ex_pc == hold_pc &&
                        id_to_ex_fields == hold_fields && id_to_ex_link == hold_link)
                else begin
                    $display("ERROR %0t: output changed while held, pc %h", $time, hold_pc);
                    errors++;
                end
            end
            if (id_to_ex_valid && ex_allowin) begin
                if (exp_q.size() == 0) begin
                    $display("extra output past the reference sequence, pc %h", id_to_ex_pc);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    checks++;
                    assert (id_to_ex_pc == e.pc && id_to_ex_fields == e.fields &&
                            id_to_ex_link == e.link)
                    else begin
                        $display("ERROR %0t: pc %h fields %h link %h, expected %h %h %h",
                                 $time, id_to_ex_pc, id_to_ex_fields, id_to_ex_link,
                                 e.pc, e.fields, e.link);
                        errors++;
                    end
                end
                n_checked++;
            end
            hold_pending = id_to_ex_valid && !ex_allowin;
            hold_pc      = id_to_ex_pc;
            hold_fields  = id_to_ex_fields;
            hold_link    = id_to_ex_link;
        end
    end

    task automatic run_test(input int num, input string name, input int mode,
                            input int n_prog, input int n_out, input logic bp);
        int          start_checked;
        int          start_errors;
        int          cycles;
        logic [31:0] pc;
        exp_t        e;
        checking = 1'b0;
        bp_on    = 1'b0;
        resetn   = 1'b0;
        start_checked = n_checked;
        start_errors  = errors + flow_errors;
        build_program(n_prog, mode);
        exp_q.delete();
        pc = `FE_RESET_PC;
        repeat (n_out) begin
            e = ref_decode(fetch_word(pc), pc);
            exp_q.push_back(e);
            pc = e.next_pc;
        end
        repeat (3) begin
            @(negedge clk);
            assert (id_to_ex_valid == 1'b0 && inst_sram_en == 1'b0)
            else begin
                $display("ERROR %0t: valid %b sram_en %b during reset in test %s",
                         $time, id_to_ex_valid, inst_sram_en, name);
                flow_errors++;
            end
        end
        resetn   = 1'b1;
        checking = 1'b1;
        bp_on    = bp;
        cycles = 0;
        while (id_to_ex_valid !== 1'b1 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        assert (id_to_ex_valid === 1'b1 && id_to_ex_pc == `FE_RESET_PC)
        else begin
            $display("ERROR %0t: first output pc %h valid %b, expected pc %h",
                     $time, id_to_ex_pc, id_to_ex_valid, `FE_RESET_PC);
            flow_errors++;
        end
        cycles = 0;
        while (n_checked - start_checked < n_out && cycles < 40 * n_out) begin
            @(negedge clk);
            cycles++;
        end
        if (n_checked - start_checked < n_out) begin
            $display("timeout in test %s, only %0d of %0d outputs arrived",
                     name, n_checked - start_checked, n_out);
            flow_errors++;
        end
        checking = 1'b0;
        $display("test %0d %s: %0d outputs, %0d errors", num, name,
                 n_checked - start_checked, errors + flow_errors - start_errors);
    endtask

    initial begin
        void'($urandom(10154));
        resetn   = 1'b0;
        checking = 1'b0;
        bp_on    = 1'b0;
        run_test(1, "reset", MODE_STRAIGHT, 16, 4, 1'b0);
        run_test(2, "straight", MODE_STRAIGHT, 48, 40, 1'b0);
        run_test(3, "branch", MODE_FORWARD, 48, 60, 1'b0);
        run_test(4, "backpressure", MODE_FORWARD, 48, 100, 1'b1);
        run_test(5, "loop", MODE_LOOP, 24, 100, 1'b1);
        $display("tests 5, checks %0d, errors %0d", checks, errors + flow_errors);
        if (errors + flow_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
